//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f src.f --top-module blimp_exec_tb -o blimp_exec_sim \
  && ./obj_dir/blimp_exec_sim 2>&1 | tee sim.log \
  && grep -q "^Done: no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- src.f
+incdir+src
src/blimp_pkg.sv
src/d_x_intf.sv
src/x_w_intf.sv
src/issue_unit.sv
src/alu_unit.sv
src/mul_unit.sv
src/writeback_commit.sv
src/blimp_exec_top.sv
tests/clk_gen.sv
tests/blimp_exec_sva.sv
tests/blimp_exec_tb.sv

//--- src/alu_unit.sv
// Single-cycle ALU pipe, add sub and or xor
// Result is registered, valid one cycle after the input

`timescale 1ns/100ps

module alu_unit
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  d_x_intf.execute d,
  x_w_intf.execute w
);

  data_t result;

  always_comb begin
    case (d.op)
      OP_ADD:  result = d.op1 + d.op2;  // 32-bit wrap
      OP_SUB:  result = d.op1 - d.op2;
      OP_AND:  result = d.op1 & d.op2;
      OP_OR:   result = d.op1 | d.op2;
      OP_XOR:  result = d.op1 ^ d.op2;
      default: result = '0;  // Mul never steered here
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) w.val <= 1'b0;
    else     w.val <= d.val;
  end

  // Payload follows val
  always_ff @(posedge clk) begin
    w.seq   <= d.seq;
    w.waddr <= d.waddr;
    w.wdata <= result;
  end

endmodule

//--- src/blimp_exec_top.sv
// Execute back end top level, plain val/rdy input and commit trace out
// Commit trace has no ready, the consumer must take every pulse
// Commit pulses also release in-flight slots in the issue unit

`timescale 1ns/100ps

module blimp_exec_top
  import blimp_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // Instruction input
  input  logic      in_val,
  output logic      in_rdy,
  input  op_t       in_op,
  input  data_t     in_op1,
  input  data_t     in_op2,
  input  reg_addr_t in_waddr,

  // Commit trace
  output logic      commit_val,
  output seq_num_t  commit_seq,
  output reg_addr_t commit_waddr,
  output data_t     commit_wdata,
  output logic      commit_wen
);

  //--------------------------------------------------------------------------
  // Pipe channels
  //--------------------------------------------------------------------------

  d_x_intf d_x_alu ();
  d_x_intf d_x_mul ();
  x_w_intf x_w_alu ();
  x_w_intf x_w_mul ();

  //--------------------------------------------------------------------------
  // Units
  //--------------------------------------------------------------------------

  issue_unit u_issue (
    .clk        (clk),
    .rst        (rst),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_op      (in_op),
    .in_op1     (in_op1),
    .in_op2     (in_op2),
    .in_waddr   (in_waddr),
    .commit_val (commit_val),  // Frees in-flight count
    .alu        (d_x_alu),
    .mul        (d_x_mul)
  );

  alu_unit u_alu (.clk(clk), .rst(rst), .d(d_x_alu), .w(x_w_alu));
  mul_unit u_mul (.clk(clk), .rst(rst), .d(d_x_mul), .w(x_w_mul));

  writeback_commit u_wcu (
    .clk          (clk),
    .rst          (rst),
    .alu          (x_w_alu),
    .mul          (x_w_mul),
    .commit_val   (commit_val),
    .commit_seq   (commit_seq),
    .commit_waddr (commit_waddr),
    .commit_wdata (commit_wdata),
    .commit_wen   (commit_wen)
  );

endmodule

//--- src/blimp_macros.svh
// Width and depth parameters for the execute back end
// ROB depth and in-flight limit both follow from the sequence width
// Multiplier depth must be at least 1

`ifndef BLIMP_MACROS_SVH
`define BLIMP_MACROS_SVH

// Sequence tag, 8 tags in flight
`define BLIMP_SEQ_BITS   3

`define BLIMP_DATA_BITS  32   // Operand and result word
`define BLIMP_REG_BITS   5    // Architectural register address

// Register stages in the multiplier pipe
`define BLIMP_MUL_STAGES 4

`endif

//--- src/blimp_pkg.sv
// Shared types for the execute back end
// Widths come from the macro header, op encoding fits in 3 bits

`include "blimp_macros.svh"

package blimp_pkg;

  //--------------------------------------------------------------------------
  // Vector types
  //--------------------------------------------------------------------------

  typedef logic [`BLIMP_SEQ_BITS-1:0]  seq_num_t;   // ROB slot tag
  typedef logic [`BLIMP_DATA_BITS-1:0] data_t;      // Operand or result
  typedef logic [`BLIMP_REG_BITS-1:0]  reg_addr_t;  // Destination reg

  //--------------------------------------------------------------------------
  // Operations
  //--------------------------------------------------------------------------

  // OP_MUL goes to the multiplier, all others to the ALU
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL
  } op_t;

endpackage

//--- src/d_x_intf.sv
// Issue to execute channel, one instance per pipe
// No ready, every pipe takes one item each cycle

`timescale 1ns/100ps

interface d_x_intf
  import blimp_pkg::*;
();

  logic      val;    // One-cycle valid
  seq_num_t  seq;    // Program order tag
  op_t       op;
  data_t     op1;    // Operands already read
  data_t     op2;
  reg_addr_t waddr;  // Destination reg, 0 means no write

  // Issue side drives everything
  modport issue (
    output val, seq, op, op1, op2, waddr
  );

  modport execute (
    input val, seq, op, op1, op2, waddr
  );

endinterface

//--- src/issue_unit.sv
// Accepts one instruction per cycle and tags it in program order
// in_rdy drops only when all 8 tags are in flight
// Outputs are registered and valid for one cycle on the chosen pipe

`timescale 1ns/100ps

`include "blimp_macros.svh"

module issue_unit
  import blimp_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_val,
  output logic      in_rdy,
  input  op_t       in_op,
  input  data_t     in_op1,
  input  data_t     in_op2,
  input  reg_addr_t in_waddr,
  input  logic      commit_val,  // One pulse per retired tag
  d_x_intf.issue    alu,
  d_x_intf.issue    mul
);

  // Full count needs one bit more than the tag
  localparam logic [`BLIMP_SEQ_BITS:0] max_in_flight = {1'b1, {`BLIMP_SEQ_BITS{1'b0}}};

  seq_num_t                seq_q;        // Next tag to hand out
  logic [`BLIMP_SEQ_BITS:0] in_flight_q;  // Accepted but not yet committed
  logic                    accept;
  logic                    is_mul;

  assign in_rdy = (in_flight_q != max_in_flight);
  assign accept = in_val && in_rdy;
  assign is_mul = (in_op == OP_MUL);

  //--------------------------------------------------------------------------
  // Tag and in-flight tracking
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      seq_q       <= '0;
      in_flight_q <= '0;
    end else begin
      if (accept) seq_q <= seq_q + 1'b1;  // Wraps mod 8
      case ({accept, commit_val})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: ;  // Both or neither leaves it unchanged
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Steering to ALU or multiplier
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      alu.val <= 1'b0;
      mul.val <= 1'b0;
    end else begin
      alu.val <= accept && !is_mul;
      mul.val <= accept && is_mul;
    end
  end

  // Payload only loads into the selected pipe
  always_ff @(posedge clk) begin
    if (accept && !is_mul) begin
      alu.seq   <= seq_q;
      alu.op    <= in_op;
      alu.op1   <= in_op1;
      alu.op2   <= in_op2;
      alu.waddr <= in_waddr;
    end
    if (accept && is_mul) begin
      mul.seq   <= seq_q;
      mul.op    <= in_op;
      mul.op1   <= in_op1;
      mul.op2   <= in_op2;
      mul.waddr <= in_waddr;
    end
  end

endmodule

//--- src/mul_unit.sv
// Pipelined 32x32 multiplier that returns only the low product word
// Product is formed into stage 0 and carried down the stages
// Accepts one item per cycle with up to BLIMP_MUL_STAGES in flight

`timescale 1ns/100ps

`include "blimp_macros.svh"

module mul_unit
  import blimp_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  d_x_intf.execute d,
  x_w_intf.execute w
);

  localparam int stages = `BLIMP_MUL_STAGES;

  logic      s_val   [stages];
  seq_num_t  s_seq   [stages];
  reg_addr_t s_waddr [stages];
  data_t     s_prod  [stages];
  data_t     product;

  // Low word is the same for signed and unsigned operands
  assign product = d.op1 * d.op2;

  //--------------------------------------------------------------------------
  // Stage shift
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < stages; i++) begin
        s_val[i] <= 1'b0;
      end
    end else begin
      s_val[0] <= d.val;
      for (int i = 1; i < stages; i++) begin
        s_val[i] <= s_val[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    s_seq[0]   <= d.seq;
    s_waddr[0] <= d.waddr;
    s_prod[0]  <= product;
    for (int i = 1; i < stages; i++) begin
      s_seq[i]   <= s_seq[i-1];
      s_waddr[i] <= s_waddr[i-1];
      s_prod[i]  <= s_prod[i-1];
    end
  end

  // Last stage feeds writeback
  assign w.val   = s_val[stages-1];
  assign w.seq   = s_seq[stages-1];
  assign w.waddr = s_waddr[stages-1];
  assign w.wdata = s_prod[stages-1];

endmodule

//--- src/writeback_commit.sv
// Reorder buffer with one slot per sequence tag
// Both pipes may write different slots in the same cycle
// Retires at most one entry per cycle and strictly in tag order
// Commit outputs are registered and need no acknowledge

`timescale 1ns/100ps

`include "blimp_macros.svh"

module writeback_commit
  import blimp_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  x_w_intf.writeback alu,
  x_w_intf.writeback mul,
  output logic       commit_val,
  output seq_num_t   commit_seq,
  output reg_addr_t  commit_waddr,
  output data_t      commit_wdata,
  output logic       commit_wen
);

  localparam int num_slots = 1 << `BLIMP_SEQ_BITS;

  logic      done_q  [num_slots];  // Result present
  reg_addr_t waddr_q [num_slots];
  data_t     wdata_q [num_slots];
  seq_num_t  head_q;               // Oldest uncommitted tag
  logic      head_done;

  assign head_done = done_q[head_q];

  //--------------------------------------------------------------------------
  // Slot state and head pointer
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      for (int i = 0; i < num_slots; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      if (head_done) begin
        done_q[head_q] <= 1'b0;      // Free slot for tag reuse
        head_q         <= head_q + 1'b1;
      end
      if (alu.val) done_q[alu.seq] <= 1'b1;
      if (mul.val) done_q[mul.seq] <= 1'b1;
    end
  end

  // Result capture into the slot chosen by tag
  always_ff @(posedge clk) begin
    if (alu.val) begin
      waddr_q[alu.seq] <= alu.waddr;
      wdata_q[alu.seq] <= alu.wdata;
    end
    if (mul.val) begin
      waddr_q[mul.seq] <= mul.waddr;
      wdata_q[mul.seq] <= mul.wdata;
    end
  end

  //--------------------------------------------------------------------------
  // Commit trace
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) commit_val <= 1'b0;
    else     commit_val <= head_done;  // One-cycle pulse per entry
  end

  always_ff @(posedge clk) begin
    commit_seq   <= head_q;
    commit_waddr <= waddr_q[head_q];
    commit_wdata <= wdata_q[head_q];
    commit_wen   <= (waddr_q[head_q] != '0);  // x0 is never written
  end

endmodule

//--- src/x_w_intf.sv
// Execute to writeback channel, one instance per pipe
// No ready, each tag owns its own ROB slot

`timescale 1ns/100ps

interface x_w_intf
  import blimp_pkg::*;
();

  logic      val;    // Result valid this cycle
  seq_num_t  seq;    // Selects ROB slot
  reg_addr_t waddr;
  data_t     wdata;  // Result word

  modport execute (
    output val, seq, waddr, wdata
  );

  // ROB side
  modport writeback (
    input val, seq, waddr, wdata
  );

endinterface

//--- tests/blimp_exec_sva.sv
// Protocol checks on the execute back end top level
// In-flight count is rebuilt here from the handshake and the commit pulses

`timescale 1ns/100ps

module blimp_exec_sva (
  input logic clk,
  input logic rst,
  input logic in_val,
  input logic in_rdy,
  input logic commit_val
);

  int   outstanding;  // Accepted, not yet committed
  logic accept;

  assign accept = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (rst) outstanding <= 0;
    else if (accept && !commit_val) outstanding <= outstanding + 1;
    else if (!accept && commit_val) outstanding <= outstanding - 1;
  end

  // Sampled mid-cycle, after the reset edge has settled the register
  commit_low_in_reset: assert property (@(negedge clk) rst |-> !commit_val)
    else $error("commit_val high while reset is asserted");

  rdy_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_rdy)
    else $error("in_rdy low in the first cycle after reset");

  // Never more than 8 tags live
  in_flight_limit: assert property (@(posedge clk) disable iff (rst)
    accept |-> outstanding < 8)
    else $error("instruction accepted with 8 already in flight");

  commit_has_owner: assert property (@(posedge clk) disable iff (rst)
    commit_val |-> outstanding > 0)
    else $error("commit pulse with nothing in flight");

endmodule

bind blimp_exec_top blimp_exec_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .in_val     (in_val),
  .in_rdy     (in_rdy),
  .commit_val (commit_val)
);

//--- tests/blimp_exec_tb.sv
// Table-driven testbench for the execute back end
// Rows are offered in order, commits are checked in table order
// Expected results are written out by hand from the op rules

`timescale 1ns/100ps

module blimp_exec_tb
  import blimp_pkg::*;
();

  localparam int num_rows   = 16;
  localparam int max_cycles = 4 + num_rows * 15 + 56;  // Reset plus worst case per row, 300

  logic      clk, rst;
  logic      in_val, in_rdy;
  op_t       in_op;
  data_t     in_op1, in_op2;
  reg_addr_t in_waddr;
  logic      commit_val, commit_wen;
  seq_num_t  commit_seq;
  reg_addr_t commit_waddr;
  data_t     commit_wdata;

  // Stimulus and expected values, one entry per row
  string     names   [num_rows];
  op_t       ops     [num_rows];
  data_t     op1s    [num_rows];
  data_t     op2s    [num_rows];
  reg_addr_t waddrs  [num_rows];
  data_t     results [num_rows];
  logic      burst   [num_rows];  // No idle gap before this row

  int seed   = 69072;
  int errors = 0;
  int commits = 0;
  int cycles = 0;
  int stalls = 0;  // Cycles with in_rdy low

  clk_gen #(.period(40), .reset_cycles(4)) u_clk (.clk(clk), .rst(rst));

  blimp_exec_top u_dut (
    .clk(clk), .rst(rst),
    .in_val(in_val), .in_rdy(in_rdy), .in_op(in_op),
    .in_op1(in_op1), .in_op2(in_op2), .in_waddr(in_waddr),
    .commit_val(commit_val), .commit_seq(commit_seq), .commit_waddr(commit_waddr),
    .commit_wdata(commit_wdata), .commit_wen(commit_wen)
  );

  task automatic set_row(input int i, input string n, input op_t op, input data_t a,
                         input data_t b, input reg_addr_t wa, input data_t r, input logic bu);
    names[i]   = n;
    ops[i]     = op;
    op1s[i]    = a;
    op2s[i]    = b;
    waddrs[i]  = wa;
    results[i] = r;
    burst[i]   = bu;
  endtask

  task automatic load_table();
    set_row(0,  "add_wrap",   OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd1,  32'h8000_0000, 1'b0);
    set_row(1,  "sub_neg",    OP_SUB, 32'h0000_0003, 32'h0000_0005, 5'd2,  32'hffff_fffe, 1'b0);
    set_row(2,  "mul_neg",    OP_MUL, 32'hffff_fffd, 32'h0000_0007, 5'd3,  32'hffff_ffeb, 1'b0);
    set_row(3,  "and_x0",     OP_AND, 32'hf0f0_1234, 32'hff00_ff00, 5'd0,  32'hf000_1200, 1'b1);
    set_row(4,  "or",         OP_OR,  32'h1200_0034, 32'h0045_6700, 5'd4,  32'h1245_6734, 1'b0);
    set_row(5,  "xor",        OP_XOR, 32'haaaa_5555, 32'hffff_0000, 5'd5,  32'h5555_5555, 1'b0);
    // Ten back-to-back multiplies
    set_row(6,  "mul_ovf",    OP_MUL, 32'h0001_0000, 32'h0001_0000, 5'd6,  32'h0000_0000, 1'b0);
    set_row(7,  "mul_ones",   OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 5'd7,  32'h0000_0001, 1'b1);
    set_row(8,  "mul_dec",    OP_MUL, 32'h0000_3039, 32'h0000_03e8, 5'd8,  32'h00bc_5ea8, 1'b1);
    set_row(9,  "mul_x0",     OP_MUL, 32'h8000_0000, 32'h0000_0002, 5'd0,  32'h0000_0000, 1'b1);
    set_row(10, "mul_sq",     OP_MUL, 32'h0000_1000, 32'h0000_1000, 5'd10, 32'h0100_0000, 1'b1);
    set_row(11, "mul_negneg", OP_MUL, 32'hffff_fffe, 32'hffff_fffb, 5'd11, 32'h0000_000a, 1'b1);
    set_row(12, "mul_one",    OP_MUL, 32'h1234_5678, 32'h0000_0001, 5'd12, 32'h1234_5678, 1'b1);
    set_row(13, "mul_carry",  OP_MUL, 32'h0001_0001, 32'h0001_0001, 5'd13, 32'h0002_0001, 1'b1);
    set_row(14, "mul_three",  OP_MUL, 32'hdead_beef, 32'h0000_0003, 5'd14, 32'h9c09_3ccd, 1'b1);
    set_row(15, "mul_half",   OP_MUL, 32'h0000_ffff, 32'h0000_ffff, 5'd31, 32'hfffe_0001, 1'b1);
  endtask

  // --------------------------------------------------------------------------
  // Driver
  // --------------------------------------------------------------------------

  initial begin : driver
    int gap;
    load_table();
    in_val   <= 1'b0;
    in_op    <= OP_ADD;
    in_op1   <= '0;
    in_op2   <= '0;
    in_waddr <= '0;
    @(negedge rst);
    @(posedge clk);
    for (int i = 0; i < num_rows; i++) begin
      gap = burst[i] ? 0 : ($random(seed) & 3);  // 0 to 3 idle cycles
      repeat (gap) begin
        in_val <= 1'b0;
        @(posedge clk);
      end
      in_val   <= 1'b1;
      in_op    <= ops[i];
      in_op1   <= op1s[i];
      in_op2   <= op2s[i];
      in_waddr <= waddrs[i];
      @(negedge clk);
      while (!in_rdy) @(negedge clk);  // Held until the issue unit has room
      @(posedge clk);                  // Transfer edge
    end
    in_val <= 1'b0;
  end

  // --------------------------------------------------------------------------
  // Commit monitor, sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge clk) begin : monitor
    int row;
    if (!rst && !in_rdy) stalls++;
    if (!rst && commit_val) begin
      row = commits;
      if (row >= num_rows) begin
        errors++;
        $display("Extra commit seen after all %0d rows had retired", num_rows);
      end else begin
        assert (commit_seq == seq_num_t'(row % 8)) else begin
          errors++;
          $display("[ERROR] %s: seq expected %0d, actual %0d", names[row], row % 8, commit_seq);
        end
        assert (commit_waddr == waddrs[row]) else begin
          errors++;
          $display("[ERROR] %s: waddr expected %0d, actual %0d",
                   names[row], waddrs[row], commit_waddr);
        end
        assert (commit_wdata == results[row]) else begin
          errors++;
          $display("[ERROR] %s: wdata expected %h, actual %h",
                   names[row], results[row], commit_wdata);
        end
        // Register 0 is never written
        assert (commit_wen == (waddrs[row] != '0)) else begin
          errors++;
          $display("[ERROR] %s: wen expected %0b, actual %0b",
                   names[row], waddrs[row] != '0, commit_wen);
        end
      end
      commits++;
    end
  end

  always @(posedge clk) cycles <= cycles + 1;

  // --------------------------------------------------------------------------
  // End of run
  // --------------------------------------------------------------------------

  initial begin : supervisor
    @(negedge rst);
    while (commits < num_rows && cycles < max_cycles) @(posedge clk);
    if (commits < num_rows) begin
      errors++;
      $display("Timeout after %0d cycles, only %0d of %0d commits arrived",
               cycles, commits, num_rows);
    end else begin
      repeat (10) @(posedge clk);  // Window for stray commits
    end
    $display("Commits %0d of %0d, stall cycles %0d, errors %0d",
             commits, num_rows, stalls, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tests/clk_gen.sv
// Testbench clock and reset source
// Reset is synchronous to the DUT, released on a rising edge

`timescale 1ns/100ps

module clk_gen #(
  parameter int period       = 40,  // ns
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Held high for a fixed number of rising edges
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
